/* files.f */
+incdir+.
stream_pkg.sv
quant_pkg.sv
skid_buffer.sv
parallelism_widen.sv
parallelism_narrow.sv
lane_activation.sv
dataflow_top.sv
tb_clock_gen.sv
tb_dataflow_top.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module tb_dataflow_top -Mdir obj_dir
	./obj_dir/Vtb_dataflow_top > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_dataflow_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dataflow_macros.svh"

module tb_dataflow_top;

    localparam quant_pkg::shift_t SHIFT = quant_pkg::shift_t'(`LEAKY_SHIFT);
    localparam int RESET_TIMEOUT = 20;
    localparam int SEND_TIMEOUT  = 5000;
    localparam int DRAIN_TIMEOUT = 400;

    logic                  clk;
    logic                  rst;
    stream_pkg::in_word_t  in_data;
    logic                  in_valid;
    logic                  in_ready;
    stream_pkg::out_word_t out_data;
    logic                  out_valid;
    logic                  out_ready;

    integer seed;
    int     error_count;
    int     check_count;
    bit     timed_out;
    int     expected_q[$];
    int     words_sent;
    int     elems_received;
    bit     in_fire_last;
    int     stall_left;
    string  current_test;

    tb_clock_gen clock_inst (
        .clk(clk),
        .rst(rst)
    );

    dataflow_top dataflow_top_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // leaky slope as a floor division by 2^SHIFT for negative inputs
    function automatic int leaky_expected(input quant_pkg::act_t x);
        int v;
        int step;
        v    = int'(x);
        step = 1 << SHIFT;
        if (v < 0) begin
            v = -((-v + step - 1) / step);
        end
        return v;
    endfunction

    // mode 0 gives non-negative values, mode 1 mixes in the corner cases
    function automatic stream_pkg::lane_t random_element(input int data_mode);
        int                r;
        stream_pkg::lane_t e;
        r = $random(seed);
        if (data_mode == 0) begin
            e = {1'b0, r[6:0]};
        end else if (r[3:0] < 4'd4) begin
            case (r[5:4])
                2'd0:    e = 8'h00;
                2'd1:    e = 8'hff;
                2'd2:    e = 8'hf8;
                default: e = 8'h80;
            endcase
        end else begin
            e = r[15:8];
        end
        return e;
    endfunction

    // the earlier element of a word sits in the higher lane
    task automatic model_push(input stream_pkg::in_word_t w);
        for (int lane = `IN_LANES - 1; lane >= 0; lane--) begin
            expected_q.push_back(leaky_expected(quant_pkg::act_t'(w[lane])));
        end
    endtask

    // one clock of stimulus, with handshakes resolved from values that
    // stay stable until the next rising edge
    task automatic drive_cycle(input int total_words, input int data_mode, input int bp_mode);
        stream_pkg::in_word_t word;
        int                   expected;
        @(negedge clk);
        if (!in_valid || in_fire_last) begin
            if (words_sent < total_words && ($random(seed) & 3) != 0) begin
                for (int lane = 0; lane < `IN_LANES; lane++) begin
                    word[lane] = random_element(data_mode);
                end
                in_data  = word;
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
        end
        if (bp_mode == 0) begin
            out_ready = (($random(seed) & 3) != 0);
        end else if (stall_left > 0) begin
            out_ready  = 1'b0;
            stall_left = stall_left - 1;
        end else if (($random(seed) & 7) == 0) begin
            stall_left = 8 + ($random(seed) & 31);
            out_ready  = 1'b0;
        end else begin
            out_ready = 1'b1;
        end
        in_fire_last = in_valid && in_ready;
        if (in_fire_last) begin
            model_push(in_data);
            words_sent++;
        end
        if (out_valid && out_ready) begin
            for (int lane = `OUT_LANES - 1; lane >= 0; lane--) begin
                if (expected_q.size() == 0) begin
                    error_count++;
                    $display("%s: an output beat arrived with no element expected",
                             current_test);
                end else begin
                    expected = expected_q.pop_front();
                    check_value({current_test, " data"}, expected,
                                32'(quant_pkg::act_t'(out_data[lane])));
                end
                elems_received++;
            end
        end
    endtask

    task automatic check_reset();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (rst && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            check_value("reset out_valid", 0, 32'(out_valid));
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            error_count++;
            timed_out = 1'b1;
            $display("reset was never released");
        end else begin
            @(negedge clk);
            check_value("post-reset out_valid", 0, 32'(out_valid));
            check_value("post-reset in_ready", 1, 32'(in_ready));
        end
    endtask

    task automatic run_test(input string name, input int total_words, input int data_mode,
                            input int bp_mode);
        int cycles;
        current_test   = name;
        words_sent     = 0;
        elems_received = 0;
        stall_left     = 0;
        cycles         = 0;
        while (words_sent < total_words && cycles < SEND_TIMEOUT) begin
            drive_cycle(total_words, data_mode, bp_mode);
            cycles++;
        end
        if (words_sent < total_words) begin
            error_count++;
            timed_out = 1'b1;
            $display("%s: the DUT accepted only %0d of %0d input words in time",
                     name, words_sent, total_words);
        end else begin
            cycles = 0;
            while (elems_received < total_words * `IN_LANES && cycles < DRAIN_TIMEOUT) begin
                drive_cycle(total_words, data_mode, bp_mode);
                cycles++;
            end
            if (elems_received < total_words * `IN_LANES) begin
                error_count++;
                timed_out = 1'b1;
                $display("%s: the output stream stopped after %0d of %0d elements",
                         name, elems_received, total_words * `IN_LANES);
            end else begin
                // idle a little longer so a duplicated beat would show up
                for (int i = 0; i < 20; i++) begin
                    drive_cycle(total_words, data_mode, bp_mode);
                end
                check_value({name, " count"}, total_words * `IN_LANES, elems_received);
                check_value({name, " drain"}, 0, expected_q.size());
            end
        end
    endtask

    initial begin
        seed           = 32'hb70d;
        error_count    = 0;
        check_count    = 0;
        timed_out      = 1'b0;
        words_sent     = 0;
        elems_received = 0;
        in_fire_last   = 1'b0;
        stall_left     = 0;
        current_test   = "reset";
        in_data        = '0;
        in_valid       = 1'b0;
        out_ready      = 1'b0;

        check_reset();
        if (!timed_out) begin
            run_test("order", 40, 0, 0);
        end
        if (!timed_out) begin
            run_test("activation", 60, 1, 0);
        end
        if (!timed_out) begin
            run_test("backpressure", 80, 1, 1);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset is released on a falling edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* dataflow_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dataflow_macros.svh"

module dataflow_top (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire stream_pkg::in_word_t in_data,
    input  wire logic                 in_valid,
    output logic                      in_ready,

    output stream_pkg::out_word_t     out_data,
    output logic                      out_valid,
    input  wire logic                 out_ready
);

    // registered copy of the two-lane input
    stream_pkg::in_word_t  in_skid_data;
    logic                  in_skid_valid;
    logic                  in_skid_ready;

    // gathered four-lane word
    stream_pkg::mid_word_t wide_data;
    logic                  wide_valid;
    logic                  wide_ready;

    // activated four-lane word
    stream_pkg::mid_word_t act_data;
    logic                  act_valid;
    logic                  act_ready;

    // registered copy ahead of the narrower
    stream_pkg::mid_word_t mid_data;
    logic                  mid_valid;
    logic                  mid_ready;

    skid_buffer #(
        .payload_t(stream_pkg::in_word_t)
    ) in_skid_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (in_skid_data),
        .out_valid(in_skid_valid),
        .out_ready(in_skid_ready)
    );

    parallelism_widen #(
        .IN_LANES (`IN_LANES),
        .OUT_LANES(`MID_LANES)
    ) widen_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (in_skid_data),
        .in_valid (in_skid_valid),
        .in_ready (in_skid_ready),
        .out_data (wide_data),
        .out_valid(wide_valid),
        .out_ready(wide_ready)
    );

    lane_activation act_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (wide_data),
        .in_valid (wide_valid),
        .in_ready (wide_ready),
        .out_data (act_data),
        .out_valid(act_valid),
        .out_ready(act_ready)
    );

    skid_buffer #(
        .payload_t(stream_pkg::mid_word_t)
    ) mid_skid_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (act_data),
        .in_valid (act_valid),
        .in_ready (act_ready),
        .out_data (mid_data),
        .out_valid(mid_valid),
        .out_ready(mid_ready)
    );

    parallelism_narrow #(
        .IN_LANES (`MID_LANES),
        .OUT_LANES(`OUT_LANES)
    ) narrow_inst (
        .clk      (clk),
        .rst      (rst),
        .in_data  (mid_data),
        .in_valid (mid_valid),
        .in_ready (mid_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

/* lane_activation.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dataflow_macros.svh"

module lane_activation (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire stream_pkg::mid_word_t in_data,
    input  wire logic                  in_valid,
    output logic                       in_ready,

    output stream_pkg::mid_word_t      out_data,
    output logic                       out_valid,
    input  wire logic                  out_ready
);

    localparam quant_pkg::shift_t SHIFT = quant_pkg::shift_t'(`LEAKY_SHIFT);

    stream_pkg::mid_word_t act_data;
    logic                  in_fire;

    // leaky ReLU on one element
    // the arithmetic shift rounds negatives toward minus infinity,
    // so -1 stays -1 and -128 becomes -16
    function automatic quant_pkg::act_t leaky(input quant_pkg::act_t x);
        quant_pkg::act_t y;
        if (x < 0) begin
            y = x >>> SHIFT;
        end else begin
            y = x;
        end
        return y;
    endfunction

    always_comb begin
        for (int i = 0; i < `MID_LANES; i++) begin
            act_data[i] = stream_pkg::lane_t'(leaky(quant_pkg::act_t'(in_data[i])));
        end
    end

    // a single output register that refills as soon as it empties
    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data <= act_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

/* parallelism_narrow.sv */
`timescale 1ns/1ps
`default_nettype none

module parallelism_narrow #(
    parameter int IN_LANES  = 4,
    parameter int OUT_LANES = 1
) (
    input  wire logic                              clk,
    input  wire logic                              rst,

    input  wire stream_pkg::lane_t [IN_LANES-1:0]  in_data,
    input  wire logic                              in_valid,
    output logic                                   in_ready,

    output stream_pkg::lane_t [OUT_LANES-1:0]      out_data,
    output logic                                   out_valid,
    input  wire logic                              out_ready
);

    // number of narrow slices carved out of one wide word
    localparam int RATIO = IN_LANES / OUT_LANES;
    localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;
    localparam logic [CNT_W-1:0] TOP_SLICE = CNT_W'(RATIO - 1);

    stream_pkg::lane_t [IN_LANES-1:0] store;
    logic                             busy;
    logic [CNT_W-1:0]                 slice;
    logic                             last_slice;
    logic                             out_fire;
    logic                             load;

    assign last_slice = (slice == '0);
    assign out_fire   = busy && out_ready;

    // take the next word when idle or as the final slice goes out,
    // which lets consecutive words stream with no bubble
    assign in_ready   = !busy || (out_ready && last_slice);
    assign load       = in_valid && in_ready;

    // present the slice the counter points at, highest first
    assign out_data   = store[int'(slice) * OUT_LANES +: OUT_LANES];
    assign out_valid  = busy;

    always_ff @(posedge clk) begin
        if (load) begin
            store <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            slice <= TOP_SLICE;
        end else if (load) begin
            busy  <= 1'b1;
            slice <= TOP_SLICE;
        end else if (out_fire) begin
            if (last_slice) begin
                busy  <= 1'b0;
                slice <= TOP_SLICE;
            end else begin
                slice <= slice - CNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

/* parallelism_widen.sv */
`timescale 1ns/1ps
`default_nettype none

module parallelism_widen #(
    parameter int IN_LANES  = 2,
    parameter int OUT_LANES = 4
) (
    input  wire logic                              clk,
    input  wire logic                              rst,

    input  wire stream_pkg::lane_t [IN_LANES-1:0]  in_data,
    input  wire logic                              in_valid,
    output logic                                   in_ready,

    output stream_pkg::lane_t [OUT_LANES-1:0]      out_data,
    output logic                                   out_valid,
    input  wire logic                              out_ready
);

    // number of narrow words gathered into one wide word
    // OUT_LANES is expected to be a whole multiple of IN_LANES
    localparam int RATIO = OUT_LANES / IN_LANES;
    localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;
    localparam logic [CNT_W-1:0] TOP_SLOT = CNT_W'(RATIO - 1);

    logic [CNT_W-1:0] slot;
    logic             in_fire;
    logic             last_slot;

    // a held wide word blocks new input unless it leaves this cycle
    assign in_ready  = !out_valid || out_ready;
    assign in_fire   = in_valid && in_ready;
    assign last_slot = (slot == '0);

    // slots fill from the top down, so the earliest word ends up
    // in the highest lanes of the wide word
    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_data[int'(slot) * IN_LANES +: IN_LANES] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot      <= TOP_SLOT;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (in_fire) begin
                if (last_slot) begin
                    // the group is complete and the word stays valid until taken
                    out_valid <= 1'b1;
                    slot      <= TOP_SLOT;
                end else begin
                    slot <= slot - CNT_W'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire payload_t in_data,
    input  wire logic     in_valid,
    output logic          in_ready,

    output payload_t      out_data,
    output logic          out_valid,
    input  wire logic     out_ready
);

    payload_t main_data;
    payload_t skid_data;
    logic     main_valid;
    logic     skid_valid;
    logic     main_load;
    logic     in_fire;

    // the spare entry being empty is all that gates the producer
    assign in_ready  = !skid_valid;
    assign in_fire   = in_valid && in_ready;

    // the main entry can take a new beat when empty or being drained
    assign main_load = !main_valid || out_ready;

    assign out_data  = main_data;
    assign out_valid = main_valid;

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        // consumer stalled with main full, so park the beat in the spare
        if (!main_load && in_fire) begin
            skid_data <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // in_fire cannot coincide with a full spare entry
            main_valid <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* quant_pkg.sv */
`default_nettype none

`include "dataflow_macros.svh"

package quant_pkg;

    // signed fixed-point activation read from a raw lane
    typedef logic signed [`DATA_WIDTH-1:0] act_t;

    // right-shift amount of 0 to 7 for the leaky slope
    typedef logic [2:0] shift_t;

endpackage

`default_nettype wire

/* stream_pkg.sv */
`default_nettype none

`include "dataflow_macros.svh"

package stream_pkg;

    // one raw element as it travels on a stream
    typedef logic [`DATA_WIDTH-1:0] lane_t;

    // two-lane word at the top input
    typedef lane_t [`IN_LANES-1:0] in_word_t;

    // four-lane word between the widener and the narrower
    typedef lane_t [`MID_LANES-1:0] mid_word_t;

    // single-lane word at the top output
    typedef lane_t [`OUT_LANES-1:0] out_word_t;

endpackage

`default_nettype wire

/* dataflow_macros.svh */
`ifndef DATAFLOW_MACROS_SVH
`define DATAFLOW_MACROS_SVH

// bits in one activation element
`define DATA_WIDTH 8

// lanes per word on each stream of the chain
`define IN_LANES 2
`define MID_LANES 4
`define OUT_LANES 1

// negative elements are scaled by 2^-LEAKY_SHIFT
`define LEAKY_SHIFT 3

`endif
